//--- mk14_pkg.sv
// Fixed constants for the loader: memory aliases above 4 KB and the display sits at 0x0D00
package mk14_pkg;

	// Memory map
	localparam int MEM_ADDR_BITS = 12;	// 4096 bytes, upper address bits are ignored
	localparam logic [15:0] SEG7_BASE_ADDR = 16'h0D00;	// Address of display digit 0
	localparam int SEG7_COUNT = 8;
	localparam int DIGIT_BITS = $clog2(SEG7_COUNT);

	// UART bit timing, shared with the serial driver of the testbench
	localparam int CLKS_PER_BIT = 8;
	localparam int BIT_CNT_BITS = $clog2(CLKS_PER_BIT);

	// Period of display refresh requests while the core runs
	localparam int REFRESH_CYCLES = 200;
	localparam int REFRESH_CNT_BITS = $clog2(REFRESH_CYCLES);

	// Parser error codes, held until the next record mark
	localparam logic [2:0] ERR_NONE = 3'd0;
	localparam logic [2:0] ERR_BAD_CHAR = 3'd1;
	localparam logic [2:0] ERR_CHECKSUM = 3'd2;
	localparam logic [2:0] ERR_REC_TYPE = 3'd3;

endpackage

//--- uart_rx.sv
// 8N1 receiver at CLKS_PER_BIT clocks per bit, no parity, a byte with a low stop bit is dropped
`timescale 1ns/1ps

module uart_rx import mk14_pkg::*; (
	input  logic clk,
	input  logic soft_reset,
	input  logic i_rx,
	output logic [7:0] o_data,
	output logic o_data_valid
);

	typedef enum logic [1:0] {
		S_IDLE, S_START, S_DATA, S_STOP
	} state_t;

	state_t state;
	logic rx_meta;
	logic rx_s;
	logic [BIT_CNT_BITS-1:0] clk_cnt;
	logic [2:0] bit_cnt;

	always_ff @(posedge clk) begin
		o_data_valid <= 1'b0;
		if (soft_reset) begin
			state <= S_IDLE;
			rx_meta <= 1'b1;	// Line idles high
			rx_s <= 1'b1;
		end
		else begin
			rx_meta <= i_rx;
			rx_s <= rx_meta;
			case (state)
			S_IDLE: begin
				clk_cnt <= '0;
				if (!rx_s)
					state <= S_START;
			end
			S_START: begin
				// Recheck the start bit at its middle to reject glitches
				if (clk_cnt == BIT_CNT_BITS'(CLKS_PER_BIT / 2 - 1)) begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					state <= rx_s ? S_IDLE : S_DATA;
				end
				else
					clk_cnt <= clk_cnt + 1'b1;
			end
			S_DATA: begin
				if (clk_cnt == BIT_CNT_BITS'(CLKS_PER_BIT - 1)) begin
					clk_cnt <= '0;
					o_data <= {rx_s, o_data[7:1]};	// LSB arrives first
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= S_STOP;
				end
				else
					clk_cnt <= clk_cnt + 1'b1;
			end
			S_STOP: begin
				if (clk_cnt == BIT_CNT_BITS'(CLKS_PER_BIT - 1)) begin
					state <= S_IDLE;
					o_data_valid <= rx_s;
				end
				else
					clk_cnt <= clk_cnt + 1'b1;
			end
			default:
				state <= S_IDLE;
			endcase
		end
	end

	a_single_strobe: assert property (@(posedge clk) disable iff (soft_reset)
		o_data_valid |=> !o_data_valid);

endmodule

//--- intel_hex.sv
// Intel HEX parser for types 00 and 01 only; data bytes are written before the checksum is checked
`timescale 1ns/1ps

module intel_hex import mk14_pkg::*; (
	input  logic clk,
	input  logic soft_reset,
	input  logic i_en,
	input  logic [7:0] i_data,
	output logic [15:0] o_addr,
	output logic [7:0] o_data,
	output logic o_data_valid,
	output logic [2:0] o_error,
	output logic o_complete
);

	typedef enum logic [2:0] {
		S_MARK, S_LENGTH, S_ADDR, S_TYPE, S_DATA, S_CSUM
	} state_t;

	// Bit 4 flags a valid hex digit, bits 3:0 hold its value
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, 4'(c - 8'h30)};
		else if (c >= "A" && c <= "F")
			r = {1'b1, 4'(c - 8'h37)};
		else if (c >= "a" && c <= "f")
			r = {1'b1, 4'(c - 8'h57)};
		return r;
	endfunction

	state_t state;
	logic [4:0] nib;
	logic low_half;	// Next digit completes a byte
	logic [3:0] hi_nib;
	logic [7:0] byte_val;
	logic [7:0] sum;
	logic [7:0] sum_next;
	logic addr_lo;
	logic [7:0] rec_len;
	logic [7:0] rec_type;
	logic [15:0] rec_addr;
	logic [7:0] offset;

	assign nib = hex_nibble(i_data);
	assign byte_val = {hi_nib, nib[3:0]};
	assign sum_next = sum + byte_val;

	always_ff @(posedge clk) begin
		o_data_valid <= 1'b0;
		o_complete <= 1'b0;
		if (soft_reset) begin
			state <= S_MARK;
			low_half <= 1'b0;
			o_error <= ERR_NONE;
		end
		else if (i_en) begin
			if (i_data == ":") begin
				// A mark always starts a new record
				state <= S_LENGTH;
				low_half <= 1'b0;
				addr_lo <= 1'b0;
				offset <= 8'd0;
				sum <= 8'd0;
				o_error <= ERR_NONE;
			end
			else if (state != S_MARK) begin
				if (!nib[4]) begin
					o_error <= ERR_BAD_CHAR;
					state <= S_MARK;
				end
				else if (!low_half) begin
					hi_nib <= nib[3:0];
					low_half <= 1'b1;
				end
				else begin
					low_half <= 1'b0;
					sum <= sum_next;
					case (state)
					S_LENGTH: begin
						rec_len <= byte_val;
						state <= S_ADDR;
					end
					S_ADDR: begin
						if (!addr_lo) begin
							rec_addr[15:8] <= byte_val;	// Big endian in the record
							addr_lo <= 1'b1;
						end
						else begin
							rec_addr[7:0] <= byte_val;
							state <= S_TYPE;
						end
					end
					S_TYPE: begin
						rec_type <= byte_val;
						if (byte_val > 8'h01) begin
							o_error <= ERR_REC_TYPE;
							state <= S_MARK;
						end
						else
							state <= (rec_len == 8'd0) ? S_CSUM : S_DATA;
					end
					S_DATA: begin
						o_addr <= rec_addr + {8'd0, offset};
						o_data <= byte_val;
						o_data_valid <= (rec_type == 8'h00);	// EOF payload is not stored
						offset <= offset + 8'd1;
						if (offset == rec_len - 8'd1)
							state <= S_CSUM;
					end
					S_CSUM: begin
						state <= S_MARK;
						if (sum_next == 8'd0)
							o_complete <= (rec_type == 8'h01);
						else
							o_error <= ERR_CHECKSUM;
					end
					default:
						state <= S_MARK;
					endcase
				end
			end
		end
	end

	a_write_or_done: assert property (@(posedge clk) disable iff (soft_reset)
		!(o_data_valid && o_complete));

endmodule

//--- mk14_mem.sv
// 4 KB byte memory, addresses alias above 0x0FFF; core writes are ignored while loading
`timescale 1ns/1ps

module mk14_mem import mk14_pkg::*; (
	input  logic clk,
	input  logic i_rx_wait,
	input  logic [15:0] i_hex_addr,
	input  logic [7:0] i_hex_data,
	input  logic i_hex_we,
	input  logic [15:0] i_core_addr,
	input  logic i_core_we,
	input  logic [7:0] i_core_wdata,
	input  logic [15:0] i_disp_addr,
	output logic [7:0] o_core_rdata,
	output logic [7:0] o_disp_rdata
);

	logic [7:0] mem [0:(1 << MEM_ADDR_BITS) - 1];
	logic wr_en;
	logic [MEM_ADDR_BITS-1:0] wr_addr;
	logic [7:0] wr_data;

	// Loader owns the write port during the load state
	assign wr_en = i_rx_wait ? i_hex_we : i_core_we;
	assign wr_addr = i_rx_wait ? i_hex_addr[MEM_ADDR_BITS-1:0] : i_core_addr[MEM_ADDR_BITS-1:0];
	assign wr_data = i_rx_wait ? i_hex_data : i_core_wdata;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Both read ports return old data on a same-cycle write
	always_ff @(posedge clk) begin
		o_core_rdata <= mem[i_core_addr[MEM_ADDR_BITS-1:0]];
		o_disp_rdata <= mem[i_disp_addr[MEM_ADDR_BITS-1:0]];
	end

endmodule

//--- run_control.sv
// Load, start and run sequencing; a refresh request is skipped when the previous scan is still busy
`timescale 1ns/1ps

module run_control import mk14_pkg::*; (
	input  logic clk,
	input  logic soft_reset,
	input  logic i_hex_complete,
	input  logic i_halt,
	input  logic i_scan_idle,
	output logic o_rx_wait,
	output logic o_core_en,
	output logic o_scan_start
);

	typedef enum logic [1:0] {
		S_LOAD, S_START, S_RUN
	} state_t;

	state_t state;
	logic [REFRESH_CNT_BITS-1:0] refresh_cnt;

	assign o_rx_wait = (state == S_LOAD);
	assign o_core_en = (state == S_RUN);

	always_ff @(posedge clk) begin
		o_scan_start <= 1'b0;
		if (soft_reset)
			state <= S_LOAD;
		else begin
			case (state)
			S_LOAD: begin
				if (i_hex_complete)
					state <= S_START;
			end
			S_START: begin
				refresh_cnt <= REFRESH_CNT_BITS'(REFRESH_CYCLES - 1);
				state <= S_RUN;
			end
			S_RUN: begin
				if (i_halt)
					state <= S_LOAD;	// Stands in for the keypad reset
				else if (refresh_cnt == '0) begin
					refresh_cnt <= REFRESH_CNT_BITS'(REFRESH_CYCLES - 1);
					o_scan_start <= i_scan_idle;
				end
				else
					refresh_cnt <= refresh_cnt - 1'b1;
			end
			default:
				state <= S_LOAD;
			endcase
		end
	end

	// The write port has no owner for one cycle when it passes from the loader to the core
	a_bus_handoff: assert property (@(posedge clk) disable iff (soft_reset)
		o_rx_wait && i_hex_complete |=> !o_rx_wait && !o_core_en ##1 o_core_en);

	// A request issued in the last running cycle before a halt would land in loading
	a_scan_in_run: assert property (@(posedge clk) disable iff (soft_reset)
		o_scan_start |-> o_core_en);

endmodule

//--- seg7_refresh.sv
// Reads SEG7_COUNT display bytes from SEG7_BASE_ADDR; a start while busy is ignored
`timescale 1ns/1ps

module seg7_refresh import mk14_pkg::*; (
	input  logic clk,
	input  logic soft_reset,
	input  logic i_start,
	input  logic [7:0] i_mem_data,
	output logic [15:0] o_mem_addr,
	output logic o_idle,
	output logic o_digit_valid,
	output logic [2:0] o_digit_index,
	output logic [7:0] o_digit_data
);

	logic busy;	// Address phase of a scan
	logic [DIGIT_BITS-1:0] digit_cnt;

	assign o_mem_addr = SEG7_BASE_ADDR + 16'(digit_cnt);
	assign o_digit_data = i_mem_data;	// Memory read latency matches the delayed valid
	assign o_idle = !busy && !o_digit_valid;

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			busy <= 1'b0;
			digit_cnt <= '0;
			o_digit_valid <= 1'b0;
		end
		else begin
			o_digit_valid <= busy;
			o_digit_index <= 3'(digit_cnt);
			if (!busy) begin
				if (i_start && o_idle) begin
					busy <= 1'b1;
					digit_cnt <= '0;
				end
			end
			else begin
				digit_cnt <= digit_cnt + 1'b1;
				if (digit_cnt == DIGIT_BITS'(SEG7_COUNT - 1))
					busy <= 1'b0;
			end
		end
	end

	// Digits come out as one unbroken burst
	a_digit_order: assert property (@(posedge clk) disable iff (soft_reset)
		o_digit_valid && o_digit_index != 3'(SEG7_COUNT - 1) |=>
			o_digit_valid && o_digit_index == $past(o_digit_index) + 3'd1);

endmodule

//--- mk14_loader_top.sv
// Loader and display refresh without the CPU; the core bus and i_halt are driven from outside
`timescale 1ns/1ps

module mk14_loader_top (
	input  logic clk,
	input  logic soft_reset,
	input  logic i_rx,
	input  logic i_halt,
	input  logic [15:0] i_core_addr,
	input  logic i_core_we,
	input  logic [7:0] i_core_wdata,
	output logic [7:0] o_core_rdata,
	output logic o_rx_wait,
	output logic o_core_en,
	output logic [2:0] o_load_error,
	output logic o_digit_valid,
	output logic [2:0] o_digit_index,
	output logic [7:0] o_digit_data
);

	logic [7:0] rx_data;
	logic rx_data_valid;
	logic rx_wait;
	logic [15:0] hex_addr;
	logic [7:0] hex_data;
	logic hex_data_valid;
	logic [2:0] hex_error;
	logic hex_complete;
	logic scan_start;
	logic scan_idle;
	logic [15:0] disp_addr;
	logic [7:0] disp_data;

	assign o_rx_wait = rx_wait;
	assign o_load_error = hex_error;

	uart_rx uart_rx_inst (
		.clk,
		.soft_reset,
		.i_rx,
		.o_data(rx_data),
		.o_data_valid(rx_data_valid)
	);

	// Serial bytes are dropped once the machine runs
	intel_hex intel_hex_inst (
		.clk,
		.soft_reset,
		.i_en(rx_data_valid && rx_wait),
		.i_data(rx_data),
		.o_addr(hex_addr),
		.o_data(hex_data),
		.o_data_valid(hex_data_valid),
		.o_error(hex_error),
		.o_complete(hex_complete)
	);

	mk14_mem mk14_mem_inst (
		.clk,
		.i_rx_wait(rx_wait),
		.i_hex_addr(hex_addr),
		.i_hex_data(hex_data),
		.i_hex_we(hex_data_valid),
		.i_core_addr,
		.i_core_we,
		.i_core_wdata,
		.i_disp_addr(disp_addr),
		.o_core_rdata,
		.o_disp_rdata(disp_data)
	);

	run_control run_control_inst (
		.clk,
		.soft_reset,
		.i_hex_complete(hex_complete),
		.i_halt,
		.i_scan_idle(scan_idle),
		.o_rx_wait(rx_wait),
		.o_core_en,
		.o_scan_start(scan_start)
	);

	seg7_refresh seg7_refresh_inst (
		.clk,
		.soft_reset,
		.i_start(scan_start),
		.i_mem_data(disp_data),
		.o_mem_addr(disp_addr),
		.o_idle(scan_idle),
		.o_digit_valid,
		.o_digit_index,
		.o_digit_data
	);

endmodule

//--- tb_mk14_loader.sv
// Testbench for the loader; only loaded or core-written addresses are read back, others stay unknown
`timescale 1ns/1ps

module tb_mk14_loader import mk14_pkg::*; ();

	localparam int NUM_DATA_RECORDS = 12;
	localparam int CHAR_CYCLES = 10 * CLKS_PER_BIT;
	// About 30 records of 40 characters with half again as margin, plus a few refresh periods
	localparam int TIMEOUT_CYCLES = 30 * 40 * CHAR_CYCLES * 3 / 2 + 8 * REFRESH_CYCLES;

	logic clk;
	logic soft_reset;
	logic i_rx;
	logic i_halt;
	logic [15:0] i_core_addr;
	logic i_core_we;
	logic [7:0] i_core_wdata;
	logic [7:0] o_core_rdata;
	logic o_rx_wait;
	logic o_core_en;
	logic [2:0] o_load_error;
	logic o_digit_valid;
	logic [2:0] o_digit_index;
	logic [7:0] o_digit_data;

	logic [7:0] ref_mem [0:(1 << MEM_ADDR_BITS) - 1];
	logic [7:0] rec_bytes [$];
	logic [15:0] loaded_addrs [$];
	integer seed;
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	int digits_checked = 0;
	logic core_owns_bus;	// Core writes reach memory only while running
	logic armed;
	logic checking;
	logic no_digits;
	logic [2:0] exp_idx;

	mk14_loader_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [7:0] expected_byte(input logic [15:0] addr);
		return ref_mem[addr[MEM_ADDR_BITS-1:0]];	// Upper bits alias
	endfunction

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		return (n < 4'd10) ? 8'h30 + {4'd0, n} : 8'h37 + {4'd0, n};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("MISMATCH %s got %h expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic check_status(input logic exp_wait, input logic exp_en, input logic [2:0] exp_err);
		@(negedge clk);
		check_value("o_rx_wait", o_rx_wait, exp_wait);
		check_value("o_core_en", o_core_en, exp_en);
		check_value("o_load_error", o_load_error, exp_err);
	endtask

	task automatic send_char(input logic [7:0] c);
		logic [9:0] frame;
		int i;
		frame = {1'b1, c, 1'b0};	// Stop, data LSB first, start
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			i_rx <= frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		send_char(hex_char(b[7:4]));
		send_char(hex_char(b[3:0]));
	endtask

	task automatic fill_random(input int len);
		int i;
		rec_bytes.delete();
		for (i = 0; i < len; i++)
			rec_bytes.push_back(8'($random(seed)));
	endtask

	// Data bytes of type 00 land in memory even when the checksum turns out wrong
	task automatic send_record(input logic [7:0] len, input logic [15:0] addr,
			input logic [7:0] rtype, input logic bad_csum);
		logic [7:0] sum;
		logic [15:0] a;
		int i;
		sum = len + addr[15:8] + addr[7:0] + rtype;
		send_char(":");
		send_byte(len);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
		send_byte(rtype);
		for (i = 0; i < int'(len); i++) begin
			send_byte(rec_bytes[i]);
			sum = sum + rec_bytes[i];
			if (rtype == 8'h00) begin
				a = addr + 16'(i);
				ref_mem[a[MEM_ADDR_BITS-1:0]] = rec_bytes[i];
				loaded_addrs.push_back(a);
			end
		end
		sum = 8'd0 - sum;
		if (bad_csum)
			sum = sum ^ 8'h5A;
		send_byte(sum);
		repeat (4) @(posedge clk);
	endtask

	task automatic core_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		i_core_addr <= addr;
		i_core_wdata <= data;
		i_core_we <= 1'b1;
		@(posedge clk);
		i_core_we <= 1'b0;
		if (core_owns_bus)
			ref_mem[addr[MEM_ADDR_BITS-1:0]] = data;
	endtask

	task automatic core_read_check(input logic [15:0] addr);
		@(posedge clk);
		i_core_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		check_value("o_core_rdata", o_core_rdata, expected_byte(addr));
	endtask

	task automatic wait_core_en();
		while (!o_core_en)
			@(posedge clk);
	endtask

	task automatic wait_digits(input int count);
		int target;
		target = digits_checked + count;
		while (digits_checked < target)
			@(posedge clk);
	endtask

	// Compares every digit strobe of an armed scan with the reference memory
	always @(negedge clk) begin
		if (!soft_reset && o_digit_valid) begin
			if (no_digits) begin
				error_count++;
				$display("ERROR: digit strobe seen while the machine is halted at %0t", $time);
			end
			if (armed && o_digit_index == 3'd0)
				checking = 1'b1;
			if (checking) begin
				check_value("o_digit_index", o_digit_index, exp_idx);
				check_value("o_digit_data", o_digit_data,
					expected_byte(SEG7_BASE_ADDR + 16'(exp_idx)));
				exp_idx = exp_idx + 3'd1;
				digits_checked++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		logic [7:0] len;
		logic [15:0] addr;
		int i;
		seed = 53293;
		soft_reset = 1'b1;
		i_rx = 1'b1;
		i_halt = 1'b0;
		i_core_addr = 16'd0;
		i_core_we = 1'b0;
		i_core_wdata = 8'd0;
		core_owns_bus = 1'b0;
		armed = 1'b0;
		checking = 1'b0;
		no_digits = 1'b0;
		exp_idx = 3'd0;
		repeat (16) @(posedge clk);
		soft_reset <= 1'b0;
		check_status(1'b1, 1'b0, ERR_NONE);
		check_value("o_digit_valid", o_digit_valid, 1'b0);

		for (i = 0; i < NUM_DATA_RECORDS; i++) begin
			len = 8'd1 + 8'($random(seed) & 15);
			addr = 16'($random(seed));
			addr = (i % 2 == 0) ? (addr | 16'h4000) : (addr & 16'h0FFF);	// Even ones alias
			fill_random(int'(len));
			send_record(len, addr, 8'h00, 1'b0);
			check_status(1'b1, 1'b0, ERR_NONE);
		end

		fill_random(4);
		send_record(8'd4, 16'($random(seed)), 8'h00, 1'b1);
		check_status(1'b1, 1'b0, ERR_CHECKSUM);
		fill_random(2);
		send_record(8'd2, 16'h0100, 8'h05, 1'b0);
		check_status(1'b1, 1'b0, ERR_REC_TYPE);
		send_char(":");
		send_char("0");
		send_char("G");
		repeat (4) @(posedge clk);
		check_status(1'b1, 1'b0, ERR_BAD_CHAR);

		// The loader owns the write port, so these must not stick
		for (i = 0; i < 4; i++)
			core_write(loaded_addrs[i], ~expected_byte(loaded_addrs[i]));

		rec_bytes.delete();
		send_record(8'd0, 16'h0000, 8'h01, 1'b0);
		wait_core_en();
		check_status(1'b0, 1'b1, ERR_NONE);
		core_owns_bus = 1'b1;
		foreach (loaded_addrs[i]) begin
			core_read_check(loaded_addrs[i]);
			core_read_check(loaded_addrs[i] ^ 16'hA000);
		end

		for (i = 0; i < SEG7_COUNT; i++)
			core_write(SEG7_BASE_ADDR + 16'(i), 8'($random(seed)));
		repeat (2) @(posedge clk);
		armed = 1'b1;
		wait_digits(2 * SEG7_COUNT);

		@(posedge clk);
		i_halt <= 1'b1;
		@(posedge clk);
		while (!o_rx_wait)
			@(posedge clk);
		i_halt <= 1'b0;
		check_status(1'b1, 1'b0, ERR_NONE);
		repeat (2 * SEG7_COUNT) @(posedge clk);	// A scan in flight still completes
		no_digits = 1'b1;
		repeat (3 * REFRESH_CYCLES) @(posedge clk);
		no_digits = 1'b0;
		core_owns_bus = 1'b0;
		send_record(8'd0, 16'h0000, 8'h01, 1'b0);
		wait_core_en();
		check_status(1'b0, 1'b1, ERR_NONE);
		core_owns_bus = 1'b1;
		wait_digits(SEG7_COUNT);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- mk14_loader_top.f
mk14_pkg.sv
uart_rx.sv
intel_hex.sv
mk14_mem.sv
run_control.sv
seg7_refresh.sv
mk14_loader_top.sv
tb_mk14_loader.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f mk14_loader_top.f \
	--top-module tb_mk14_loader -o sim_mk14 > build.log 2>&1 \
	&& ./obj_dir/sim_mk14 > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
